//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP       := gb_bus_core_tb
RTL_TOP   := gb_bus_core
FILELIST  := gb_bus_core.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale 1ns/1ps --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- gb_bus_core.f
+incdir+source
source/gb_bus_pkg.sv
source/gb_addr_decode.sv
source/gb_irq_ctrl.sv
source/gb_wram.sv
source/gb_sys_regs.sv
source/gb_bus_core.sv
verif/gb_bus_core_props.sv
verif/gb_bus_core_tb.sv

//--- source/gb_addr_decode.sv
`default_nettype none

`include "gb_bus_settings.svh"

// cpu address -> bus region
// the only place where address ranges get looked at
module gb_addr_decode import gb_bus_pkg::*; (
	input  logic [15:0] cpu_addr,
	input  logic        is_gbc,
	output bus_region_t region
);

	logic sel_wram;
	logic sel_high;

	// c000-fdff, echo e000-fdff folds onto c000-ddff in the ram
	assign sel_wram = (cpu_addr[15:14] == 2'b11) && !(&cpu_addr[13:9]);
	assign sel_high = (cpu_addr[15:8] == 8'hff); // io page + ie

	always_comb begin
		region = region_none; // default: open bus
		if (sel_wram) begin
			region = region_wram;
		end else if (sel_high) begin
			case (cpu_addr)
				`GB_ADDR_IF:   region = region_if;
				`GB_ADDR_IE:   region = region_ie;
				`GB_ADDR_P1:   region = region_p1;
				`GB_ADDR_BOOT: region = region_boot;
				`GB_ADDR_SVBK: begin
					if (is_gbc) // dmg has no wram banking
						region = region_svbk;
				end
				`GB_ADDR_KEY1: begin
					if (is_gbc) // no double speed on dmg
						region = region_key1;
				end
				default:       region = region_none;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/gb_bus_core.sv
`default_nettype none

`include "gb_bus_settings.svh"

// memory and io glue around the cpu bus
module gb_bus_core import gb_bus_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_ss,
	input  logic        ce,
	input  logic        is_gbc,
	input  logic        fast_boot,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dout,
	input  logic        cpu_wr_n,
	input  logic        cpu_rd_n, // read data is driven regardless
	input  logic        cpu_iorq_n,
	input  logic        cpu_m1_n,
	input  logic        cpu_stop,
	input  logic        vblank_irq,
	input  logic        lcd_irq,
	input  logic        timer_irq,
	input  logic        serial_irq,
	input  logic [3:0]  joy_din,
	output logic [7:0]  cpu_din,
	output logic        irq_n,
	output logic        speed,
	output logic [1:0]  joy_p54
);

	bus_region_t region;
	logic [7:0]  irq_vec;
	logic [4:0]  if_val;
	logic [7:0]  ie_val;
	logic [7:0]  wram_do;
	logic [2:0]  bank;
	logic        prepare_switch;
	logic        boot_rom_enabled;
	logic        irq_ack;

	gb_addr_decode decode_i (.cpu_addr(cpu_addr), .is_gbc(is_gbc), .region(region));

	gb_irq_ctrl irq_i (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce(ce), .region(region),
		.cpu_wr_n(cpu_wr_n), .cpu_dout(cpu_dout),
		.cpu_iorq_n(cpu_iorq_n), .cpu_m1_n(cpu_m1_n),
		.vblank_irq(vblank_irq), .lcd_irq(lcd_irq), .timer_irq(timer_irq),
		.serial_irq(serial_irq), .joy_din(joy_din),
		.irq_n(irq_n), .irq_vec(irq_vec), .if_val(if_val), .ie_val(ie_val)
	);

	gb_wram wram_i (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce(ce), .region(region),
		.cpu_addr(cpu_addr), .cpu_wr_n(cpu_wr_n), .cpu_dout(cpu_dout),
		.rd_data(wram_do), .bank(bank)
	);

	gb_sys_regs sys_i (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .ce(ce), .region(region),
		.cpu_wr_n(cpu_wr_n), .cpu_dout(cpu_dout), .cpu_stop(cpu_stop), .is_gbc(is_gbc),
		.speed(speed), .prepare_switch(prepare_switch), .joy_p54(joy_p54),
		.boot_rom_enabled(boot_rom_enabled)
	);

	// ------------------------------------------------------------
	// cpu read mux
	// ------------------------------------------------------------

	assign irq_ack = !cpu_iorq_n && !cpu_m1_n; // vector goes out during ack

	always_comb begin
		if (irq_ack) begin
			cpu_din = irq_vec;
		end else begin
			case (region)
				region_wram: cpu_din = wram_do; // registered, valid a cycle later
				region_if:   cpu_din = {3'b111, if_val};
				region_ie:   cpu_din = ie_val;
				region_svbk: cpu_din = {5'b11111, bank};
				region_key1: cpu_din = {speed, 6'b111111, prepare_switch};
				region_p1:   cpu_din = {2'b11, joy_p54, joy_din};
				region_boot: cpu_din = (fast_boot && boot_rom_enabled) ?
					`GB_FAST_BOOT_FLAG : `GB_OPEN_BUS;
				default:     cpu_din = `GB_OPEN_BUS; // cart, vram etc. not here
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/gb_bus_pkg.sv
`default_nettype none

// ------------------------------------------------------------
// shared types for the console bus glue
// ------------------------------------------------------------

package gb_bus_pkg;

	// decoded target of the current cpu address
	// produced by gb_addr_decode only, everyone else just compares
	typedef enum logic [2:0] {
		region_none = 3'd0, // open bus, reads ffh
		region_wram = 3'd1, // c000-fdff incl. echo
		region_if   = 3'd2, // ff0f
		region_ie   = 3'd3, // ffff
		region_svbk = 3'd4, // ff70, cgb only
		region_key1 = 3'd5, // ff4d, cgb only
		region_p1   = 3'd6, // ff00 joypad
		region_boot = 3'd7  // ff50 boot rom latch
	} bus_region_t;

	// interrupt sources, highest priority first
	// value doubles as bit index into IF / IE
	typedef enum logic [2:0] {
		irq_vblank = 3'd0,
		irq_lcd    = 3'd1,
		irq_timer  = 3'd2,
		irq_serial = 3'd3,
		irq_joypad = 3'd4
	} irq_src_t;

endpackage

`default_nettype wire

//--- source/gb_bus_settings.svh
`ifndef GB_BUS_SETTINGS_SVH
`define GB_BUS_SETTINGS_SVH

// ------------------------------------------------------------
// high page register addresses
// ------------------------------------------------------------

`define GB_ADDR_P1        16'hff00 // joypad select
`define GB_ADDR_IF        16'hff0f // interrupt flags
`define GB_ADDR_KEY1      16'hff4d // speed switch, cgb
`define GB_ADDR_BOOT      16'hff50 // boot rom disable
`define GB_ADDR_SVBK      16'hff70 // wram bank, cgb
`define GB_ADDR_IE        16'hffff // interrupt enable

// ------------------------------------------------------------
// interrupt vectors
// ------------------------------------------------------------

// vector = base + step * source index
`define GB_IRQ_VEC_BASE   8'h40
`define GB_IRQ_VEC_STEP   8'h08

// ------------------------------------------------------------
// fixed read values and reset values
// ------------------------------------------------------------

`define GB_FAST_BOOT_FLAG 8'h42 // seen by boot code at ff50
`define GB_OPEN_BUS       8'hff // nothing drives the bus
`define GB_WRAM_BANK_RESET 3'd1 // bank 0 is never selectable at d000

`endif

//--- source/gb_irq_ctrl.sv
`default_nettype none

`include "gb_bus_settings.svh"

// IF / IE registers, event edge detect, vector and ack clearing
module gb_irq_ctrl import gb_bus_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_ss,
	input  logic        ce,
	input  bus_region_t region,
	input  logic        cpu_wr_n,
	input  logic [7:0]  cpu_dout,
	input  logic        cpu_iorq_n,
	input  logic        cpu_m1_n,
	input  logic        vblank_irq,
	input  logic        lcd_irq,
	input  logic        timer_irq,
	input  logic        serial_irq,
	input  logic [3:0]  joy_din,
	output logic        irq_n,
	output logic [7:0]  irq_vec,
	output logic [4:0]  if_val,
	output logic [7:0]  ie_val
);

	logic [4:0] if_r;      // flags, bit = irq_src_t
	logic [7:0] ie_r;      // all 8 bits r/w, only 4:0 matter
	logic [3:0] evt;
	logic [3:0] old_evt;   // previous event levels
	logic [3:0] evt_rise;
	logic [3:0] joy_d1;
	logic [3:0] joy_d2;
	logic       joy_fall;
	logic       irq_ack;
	logic       old_ack;
	logic       ack_end;
	logic [4:0] pend;
	logic       any_pend;
	irq_src_t   win;
	logic [4:0] if_next;
	logic       if_wr;
	logic       ie_wr;

	// ------------------------------------------------------------
	// event edges
	// ------------------------------------------------------------

	assign evt      = {serial_irq, timer_irq, lcd_irq, vblank_irq};
	assign evt_rise = evt & ~old_evt;
	assign joy_fall = |(~joy_d1 & joy_d2); // any P1x line pulled low

	// ------------------------------------------------------------
	// priority and vector
	// ------------------------------------------------------------

	assign pend     = if_r & ie_r[4:0];
	assign any_pend = |pend;
	assign irq_n    = !any_pend;

	always_comb begin
		win = irq_joypad;
		for (int i = 4; i >= 0; i--) begin // lowest index wins
			if (pend[i])
				win = irq_src_t'(i);
		end
	end

	assign irq_vec = any_pend ? (`GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * {5'd0, win}) : 8'h00;

	// ack cycle = iorq and m1 low together, clear on its trailing edge
	assign irq_ack = !cpu_iorq_n && !cpu_m1_n;
	assign ack_end = old_ack && !irq_ack;

	assign if_wr = !cpu_wr_n && (region == region_if);
	assign ie_wr = !cpu_wr_n && (region == region_ie);

	always_comb begin
		if_next = if_r | {joy_fall, evt_rise};
		if (ack_end && any_pend)
			if_next[win] = 1'b0; // ack beats a new edge on same bit
		if (if_wr)
			if_next = cpu_dout[4:0]; // cpu write overrides everything
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r    <= '0;
			ie_r    <= '0;
			old_evt <= '0;
			joy_d1  <= '0;
			joy_d2  <= '0;
			old_ack <= 1'b0;
		end else if (ce) begin
			old_evt <= evt;
			joy_d1  <= joy_din; // two stage sync
			joy_d2  <= joy_d1;
			old_ack <= irq_ack;
			if_r    <= if_next;
			if (ie_wr)
				ie_r <= cpu_dout;
		end
	end

	assign if_val = if_r;
	assign ie_val = ie_r;

endmodule

`default_nettype wire

//--- source/gb_sys_regs.sv
`default_nettype none

`include "gb_bus_settings.svh"

// KEY1 speed switch, P1 select bits, boot rom latch
module gb_sys_regs import gb_bus_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_ss,
	input  logic        ce,
	input  bus_region_t region,
	input  logic        cpu_wr_n,
	input  logic [7:0]  cpu_dout,
	input  logic        cpu_stop,
	input  logic        is_gbc,
	output logic        speed,
	output logic        prepare_switch,
	output logic [1:0]  joy_p54,
	output logic        boot_rom_enabled
);

	logic key1_wr;
	logic p1_wr;
	logic boot_wr;
	logic boot_off;

	assign key1_wr = !cpu_wr_n && (region == region_key1);
	assign p1_wr   = !cpu_wr_n && (region == region_p1);
	assign boot_wr = !cpu_wr_n && (region == region_boot);

	// cgb wants exactly 11h while dmg only checks bit 0
	assign boot_off = is_gbc ? (cpu_dout == 8'h11) : cpu_dout[0];

	// ------------------------------------------------------------
	// KEY1
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			speed          <= 1'b0; // normal speed
			prepare_switch <= 1'b0;
		end else if (ce) begin
			if (key1_wr)
				prepare_switch <= cpu_dout[0]; // only bit 0 writable
			// stop with prepare armed flips the speed
			if (is_gbc && prepare_switch && cpu_stop) begin
				speed          <= !speed;
				prepare_switch <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// P1 select and boot latch
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			joy_p54          <= 2'b00;
			boot_rom_enabled <= 1'b1; // boot rom mapped after reset
		end else if (ce) begin
			if (p1_wr)
				joy_p54 <= {cpu_dout[4], cpu_dout[5]}; // p14 select lands in bit 1
			if (boot_wr && boot_off)
				boot_rom_enabled <= 1'b0; // only reset re-enables
		end
	end

endmodule

`default_nettype wire

//--- source/gb_wram.sv
`default_nettype none

`include "gb_bus_settings.svh"

// 32 KB work ram, bank 0 fixed at c000, svbk bank at d000
module gb_wram import gb_bus_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_ss,
	input  logic        ce,
	input  bus_region_t region,
	input  logic [15:0] cpu_addr,
	input  logic        cpu_wr_n,
	input  logic [7:0]  cpu_dout,
	output logic [7:0]  rd_data,
	output logic [2:0]  bank
);

	logic [7:0]  mem [0:32767];
	logic [14:0] ram_addr;
	logic        ram_we;

	// ------------------------------------------------------------
	// svbk
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			bank <= `GB_WRAM_BANK_RESET;
		end else if (ce && !cpu_wr_n && (region == region_svbk)) begin
			if (cpu_dout[2:0] == 3'd0)
				bank <= 3'd1; // 0 maps to 1
			else
				bank <= cpu_dout[2:0];
		end
	end

	// ------------------------------------------------------------
	// ram array
	// ------------------------------------------------------------

	// bit 12 picks the switchable half, echo follows the same rule
	assign ram_addr = cpu_addr[12] ? {bank, cpu_addr[11:0]} : {3'd0, cpu_addr[11:0]};
	assign ram_we   = ce && !cpu_wr_n && (region == region_wram);

	always_ff @(posedge clk_sys) begin
		if (ram_we)
			mem[ram_addr] <= cpu_dout;
		if (ce)
			rd_data <= mem[ram_addr]; // one cycle read latency
	end

endmodule

`default_nettype wire

//--- verif/gb_bus_core_patterns.txt
# op addr data expect, all hex; cfg data = {ce, fast_boot, is_gbc}
# event data = {joy_din, serial, timer, lcd, vblank}; pins expect = {speed, joy_p54, irq_n}
test  0001 00 00
read  ff0f 00 e0
read  ffff 00 00
read  ff70 00 f9
read  ff4d 00 7e
read  ff50 00 42
pins  0000 00 01
test  0002 00 00
write ff70 02 00
write d000 a5 00
write ff70 05 00
write d000 5a 00
read  d000 00 5a
write ff70 02 00
read  d000 00 a5
write c000 3c 00
write ff70 05 00
read  c000 00 3c
write ff70 00 00
read  ff70 00 f9
read  e000 00 3c
test  0003 00 00
write ffff 1f 00
event 0000 f5 00
read  ff0f 00 e5
pins  0000 00 00
ack   0000 00 40
read  ff0f 00 e4
ack   0000 00 50
read  ff0f 00 e0
event 0000 f0 00
test  0004 00 00
event 0000 e0 00
poll  ff0f 10 10
write ff00 20 00
read  ff00 00 de
pins  0000 00 02
write ff0f 00 00
event 0000 f0 00
pins  0000 00 03
test  0005 00 00
write ff4d 01 00
read  ff4d 00 7f
stop  0000 00 00
read  ff4d 00 fe
pins  0000 00 0b
write ff50 11 00
read  ff50 00 ff
test  0006 00 00
cfg   0000 03 00
write ff0f 1f 00
write ffff 00 00
write ff70 03 00
write ff4d 01 00
write ff00 10 00
event 0000 0f 00
read  ff0f 00 e0
read  ffff 00 1f
read  ff70 00 f9
read  ff4d 00 fe
read  ff00 00 d0
pins  0000 00 0b
event 0000 f0 00
cfg   0000 07 00
read  ff0f 00 e0

//--- verif/gb_bus_core_props.sv
`default_nettype none

`include "gb_bus_settings.svh"

// interrupt controller properties bound into gb_irq_ctrl
module gb_bus_core_props import gb_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_ss,
	input  logic       ce,
	input  logic       irq_n,
	input  logic [7:0] irq_vec,
	input  logic [4:0] if_val,
	input  logic [7:0] ie_val
);
	timeunit 1ns;
	timeprecision 1ps;

	// highest legal vector belongs to joypad
	localparam logic [7:0] vec_last = `GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * {5'd0, irq_joypad};

	logic [4:0] shared;  // raised and enabled
	logic [2:0] vec_idx; // source index carried by the vector

	assign shared  = if_val & ie_val[4:0];
	assign vec_idx = 3'((irq_vec - `GB_IRQ_VEC_BASE) / `GB_IRQ_VEC_STEP);

	irq_line: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_n == !(|shared)) // low only with a shared bit
		else $error("irq_n does not match the IF and IE overlap");

	// vector must name a pending source with nothing higher pending
	vec_legal: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_n ? (irq_vec == 8'h00) :
		(irq_vec >= `GB_IRQ_VEC_BASE && irq_vec <= vec_last && irq_vec[2:0] == 3'd0 &&
		shared[vec_idx] && (shared & ((5'd1 << vec_idx) - 5'd1)) == 5'd0))
		else $error("irq vector %02h is not the vector of the top pending source", irq_vec);

	// flags frozen while the enable is low
	if_hold: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!ce |=> $stable(if_val))
		else $error("IF changed during a cycle with ce low");

endmodule

bind gb_irq_ctrl gb_bus_core_props props_i (
	.clk_sys(clk_sys), .reset_ss(reset_ss), .ce(ce), .irq_n(irq_n),
	.irq_vec(irq_vec), .if_val(if_val), .ie_val(ie_val)
);

`default_nettype wire

//--- verif/gb_bus_core_tb.sv
`default_nettype none

// bus glue testbench driven by one pattern line per bus operation
module gb_bus_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int poll_cycles = 3; // joypad sync needs at most three

	logic        clk_sys;
	logic        reset_ss;
	logic        ce;
	logic        is_gbc;
	logic        fast_boot;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        cpu_wr_n;
	logic        cpu_rd_n;
	logic        cpu_iorq_n;
	logic        cpu_m1_n;
	logic        cpu_stop;
	logic        vblank_irq;
	logic        lcd_irq;
	logic        timer_irq;
	logic        serial_irq;
	logic [3:0]  joy_din;
	logic [7:0]  cpu_din;
	logic        irq_n;
	logic        speed;
	logic [1:0]  joy_p54;

	int          fd;
	string       line;
	string       op;
	logic [15:0] addr;
	logic [7:0]  data;
	logic [7:0]  expect_v;
	int          errors;
	int          checks;
	int          test_no;
	int          test_errs;   // error count when the current test began
	int          tests_done;
	int          tests_failed;

	gb_bus_core dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ------------------------------------------------------------
	// bus operations driven on the falling edge
	// ------------------------------------------------------------

	task automatic compare_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
		end
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_dout = d;
		cpu_wr_n = 1'b0;
		@(negedge clk_sys);
		cpu_wr_n = 1'b1; // single write cycle
	endtask

	task automatic bus_read(input logic [15:0] a, input logic [7:0] expected);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_rd_n = 1'b0;
		@(negedge clk_sys); // wram data lands on the edge in between
		compare_value($sformatf("cpu_din @ %04h", a), expected, cpu_din);
		cpu_rd_n = 1'b1;
	endtask

	// wait for masked register bits with a cycle limit
	task automatic poll_reg(input logic [15:0] a, input logic [7:0] mask,
		input logic [7:0] expected);
		int n;
		@(negedge clk_sys);
		cpu_addr = a;
		@(negedge clk_sys);
		n = 1;
		while ((cpu_din & mask) !== expected && n < poll_cycles) begin
			@(negedge clk_sys);
			n++;
		end
		if ((cpu_din & mask) !== expected)
			$display("timeout: register %04h did not reach %02h under mask %02h in %0d cycles",
				a, expected, mask, poll_cycles);
		compare_value($sformatf("cpu_din @ %04h masked %02h", a, mask), expected,
			cpu_din & mask);
	endtask

	task automatic ack_cycle(input logic [7:0] expected);
		@(negedge clk_sys);
		cpu_iorq_n = 1'b0;
		cpu_m1_n   = 1'b0;
		@(negedge clk_sys);
		compare_value("cpu_din (ack vector)", expected, cpu_din);
		cpu_iorq_n = 1'b1; // flag clears on the next edge
		cpu_m1_n   = 1'b1;
	endtask

	task automatic stop_pulse();
		@(negedge clk_sys);
		cpu_stop = 1'b1;
		@(negedge clk_sys);
		cpu_stop = 1'b0;
	endtask

	task automatic set_events(input logic [7:0] d);
		@(negedge clk_sys);
		joy_din = d[7:4];
		{serial_irq, timer_irq, lcd_irq, vblank_irq} = d[3:0];
	endtask

	task automatic set_config(input logic [7:0] d);
		@(negedge clk_sys);
		is_gbc    = d[0];
		fast_boot = d[1];
		ce        = d[2];
	endtask

	task automatic check_pins(input logic [7:0] expected);
		@(negedge clk_sys);
		compare_value("speed/joy_p54/irq_n", expected, {4'b0, speed, joy_p54, irq_n});
	endtask

	task automatic close_test();
		if (test_no > 0) begin
			tests_done++;
			if (errors == test_errs)
				$display("test %0d passed", test_no);
			else begin
				tests_failed++;
				$display("test %0d failed, %0d mismatches", test_no, errors - test_errs);
			end
		end
	endtask

	task automatic run_op();
		case (op)
			"test": begin
				close_test();
				test_no   = int'(addr);
				test_errs = errors;
			end
			"cfg":   set_config(data);
			"write": bus_write(addr, data);
			"read":  bus_read(addr, expect_v);
			"poll":  poll_reg(addr, data, expect_v);
			"event": set_events(data);
			"ack":   ack_cycle(expect_v);
			"stop":  stop_pulse();
			"pins":  check_pins(expect_v);
			default: begin
				errors++;
				$display("unknown operation %s in the pattern file", op);
			end
		endcase
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------

	initial begin
		reset_ss   = 1'b1;
		ce         = 1'b1;
		is_gbc     = 1'b1;
		fast_boot  = 1'b1;
		cpu_addr   = 16'h0000;
		cpu_dout   = 8'h00;
		cpu_wr_n   = 1'b1;
		cpu_rd_n   = 1'b1;
		cpu_iorq_n = 1'b1;
		cpu_m1_n   = 1'b1;
		cpu_stop   = 1'b0;
		{serial_irq, timer_irq, lcd_irq, vblank_irq} = 4'h0;
		joy_din    = 4'hf; // no buttons pressed
		errors = 0;
		checks = 0;
		test_no = 0;
		test_errs = 0;
		tests_done = 0;
		tests_failed = 0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_ss = 1'b0;

		fd = $fopen("verif/gb_bus_core_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open verif/gb_bus_core_patterns.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line[0] != "#" &&
					$sscanf(line, "%s %h %h %h", op, addr, data, expect_v) == 4)
					run_op();
			end
			$fclose(fd);
			close_test();
		end

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_done, tests_failed, checks, errors);
		if (errors == 0 && tests_done > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
